/* hdl/cw_io_settings.svh */
`ifndef CW_IO_SETTINGS_SVH
`define CW_IO_SETTINGS_SVH

// register bus widths
`define CW_ADDR_WIDTH         8
`define CW_BYTECNT_WIDTH      7
`define CW_DATA_WIDTH         8

// target side sizes
`define CW_NUM_PINS           4
`define CW_NUM_TRIG_SRC       6     // aux, nrst, io1, io2, io3, io4
`define CW_OC_PIN             2     // pin 3, only one with forced low / open collector

// register map
`define CW_TRIGSRC_ADDR       8'h27 // source mask + combine mode
`define CW_TRIGMOD_ADDR       8'h28 // trigger module select
`define CW_IOROUTE_ADDR       8'h37 // routing, 8 bytes by byte count
`define CW_IOREAD_ADDR        8'h3b // sampled pin levels, read only
`define CW_IOROUTE_BYTES      8

// reset values
`define CW_TRIGSRC_RESET      8'h20 // or of io4 alone
`define CW_TRIGMOD_RESET      8'h00 // edge module
`define CW_IOROUTE_RESET      64'h0000_0000_0000_0201 // pin 1 tx, pin 2 rx

// trigsrc fields
`define CW_TRIGSRC_MODE_LSB   6     // mode in [7:6], mask in [5:0]

// routing byte bits, bytes 0..3 are pins 1..4
`define ROUTE_TX              0
`define ROUTE_RX              1
`define ROUTE_LOW             4     // pin 3 only
`define ROUTE_OC              5     // pin 3 only
`define ROUTE_LEVEL           6
`define ROUTE_GPIO            7

// extra routing bytes
`define CW_EXTRA_BYTE         5
`define CW_AVRPROG_BIT        0
`define CW_POWER_OFF_BIT      1
`define CW_GPIO_BYTE          6     // {pdic, pdic_en, pdid, pdid_en, nrst, nrst_en}

`endif

/* hdl/cw_io_pkg.sv */
package cw_io_pkg;

   // how the enabled external sources are merged, trigsrc[7:6]
   typedef enum logic [1:0] {
      COMBINE_OR   = 2'b00,
      COMBINE_AND  = 2'b01,
      COMBINE_NAND = 2'b10,
      COMBINE_OFF  = 2'b11  // trigger_ext held low
   } trig_combine_e;

   // trigger module feeding trigger_o, trigmod[2:0]
   typedef enum logic [2:0] {
      MOD_EDGE      = 3'b000, // combined external trigger
      MOD_ADVIO     = 3'b001,
      MOD_SAD       = 3'b010,
      MOD_DECODEDIO = 3'b011,
      MOD_TRACE     = 3'b100,
      MOD_ADC       = 3'b101,
      MOD_EDGE_DET  = 3'b110,
      MOD_NONE      = 3'b111  // no trigger
   } trig_module_e;

endpackage

/* hdl/cw_reg_file.sv */
`timescale 1ns/100ps
`include "cw_io_settings.svh"

module cw_reg_file
   import cw_io_pkg::*;
(
   input  logic                          clk_usb,
   input  logic                          reset,

   // register bus
   input  logic [`CW_ADDR_WIDTH-1:0]     reg_address_i,
   input  logic [`CW_BYTECNT_WIDTH-1:0]  reg_bytecnt_i,
   input  logic [`CW_DATA_WIDTH-1:0]     reg_data_i,
   input  logic                          reg_read_i,
   input  logic                          reg_write_i,
   output logic [`CW_DATA_WIDTH-1:0]     reg_data_o,

   // sampled pins for ioread
   input  logic [`CW_NUM_PINS-1:0]       io_sample_i,

   // trigger config
   output logic [`CW_NUM_TRIG_SRC-1:0]   trig_src_en_o,
   output trig_combine_e                 trig_combine_o,
   output trig_module_e                  trig_module_o,

   // io config
   output logic [8*`CW_NUM_PINS-1:0]     pin_route_o,
   output logic                          power_off_req_o,
   output logic                          avrprog_en_o,
   output logic [2:0]                    extra_gpio_oe_o,   // pdic, pdid, nrst
   output logic [2:0]                    extra_gpio_o
);

   logic [`CW_DATA_WIDTH-1:0]  trigsrc_q;
   logic [`CW_DATA_WIDTH-1:0]  trigmod_q;
   logic [63:0]                ioroute_q;      // 8 routing bytes
   logic                       route_byte_ok;  // bytecnt within 0..7
   logic [5:0]                 route_lsb;      // bit offset of addressed byte
   logic [7:0]                 extra_byte;
   logic [7:0]                 gpio_byte;

   assign route_byte_ok = (reg_bytecnt_i < `CW_BYTECNT_WIDTH'(`CW_IOROUTE_BYTES));
   assign route_lsb     = {reg_bytecnt_i[2:0], 3'b000};

   // writes land on the next edge
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trigsrc_q <= `CW_TRIGSRC_RESET;
         trigmod_q <= `CW_TRIGMOD_RESET;
         ioroute_q <= `CW_IOROUTE_RESET;
      end else if (reg_write_i) begin
         case (reg_address_i)
            `CW_TRIGSRC_ADDR: trigsrc_q <= reg_data_i;
            `CW_TRIGMOD_ADDR: trigmod_q <= reg_data_i;
            `CW_IOROUTE_ADDR: begin
               if (route_byte_ok) ioroute_q[route_lsb +: 8] <= reg_data_i; // high bytecnt dropped
            end
            default: ;                              // unknown or read-only address
         endcase
      end
   end

   // read byte, zero when idle
   always_comb begin
      reg_data_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            `CW_TRIGSRC_ADDR: reg_data_o = trigsrc_q;
            `CW_TRIGMOD_ADDR: reg_data_o = trigmod_q;
            `CW_IOROUTE_ADDR: begin
               if (route_byte_ok) reg_data_o = ioroute_q[route_lsb +: 8];
            end
            `CW_IOREAD_ADDR:  reg_data_o = `CW_DATA_WIDTH'(io_sample_i); // zero extended
            default:          reg_data_o = '0;
         endcase
      end
   end

   // trigger fields
   assign trig_src_en_o  = trigsrc_q[`CW_NUM_TRIG_SRC-1:0];
   assign trig_combine_o = trig_combine_e'(trigsrc_q[`CW_TRIGSRC_MODE_LSB +: 2]);
   assign trig_module_o  = trig_module_e'(trigmod_q[2:0]);   // upper bits kept for readback

   // pin routing, bytes 0..3
   assign pin_route_o = ioroute_q[8*`CW_NUM_PINS-1:0];

   // byte 5, avr prog and target power
   assign extra_byte      = ioroute_q[`CW_EXTRA_BYTE*8 +: 8];
   assign avrprog_en_o    = extra_byte[`CW_AVRPROG_BIT];
   assign power_off_req_o = extra_byte[`CW_POWER_OFF_BIT];

   // byte 6, enable/level pairs
   assign gpio_byte       = ioroute_q[`CW_GPIO_BYTE*8 +: 8];
   assign extra_gpio_oe_o = {gpio_byte[4], gpio_byte[2], gpio_byte[0]};
   assign extra_gpio_o    = {gpio_byte[5], gpio_byte[3], gpio_byte[1]};

endmodule

/* hdl/trigger_select.sv */
`timescale 1ns/100ps
`include "cw_io_settings.svh"

module trigger_select
   import cw_io_pkg::*;
(
   // config from register file
   input  logic [`CW_NUM_TRIG_SRC-1:0] trig_src_en_i,
   input  trig_combine_e               trig_combine_i,
   input  trig_module_e                trig_module_i,

   // external sources
   input  logic                        trigger_aux_i,
   input  logic                        trigger_nrst_i,
   input  logic [`CW_NUM_PINS-1:0]     trigger_io_i,     // io1 in bit 0

   // module triggers
   input  logic                        trigger_advio_i,
   input  logic                        trigger_sad_i,
   input  logic                        trigger_decodedio_i,
   input  logic                        trigger_trace_i,
   input  logic                        trigger_adc_i,
   input  logic                        trigger_edge_i,

   output logic                        trigger_o,
   output logic                        trigger_ext_o,
   output logic                        decodeio_active_o,
   output logic                        sad_active_o,
   output logic                        edge_trigger_active_o
);

   logic [`CW_NUM_TRIG_SRC-1:0] src;  // same order as the mask
   logic                        src_or;
   logic                        src_and;

   assign src = {trigger_io_i, trigger_nrst_i, trigger_aux_i};

   assign src_or  = |(src & trig_src_en_i);
   assign src_and = &(src | ~trig_src_en_i);  // disabled source reads as 1

   always_comb begin
      case (trig_combine_i)
         COMBINE_OR:   trigger_ext_o = src_or;
         COMBINE_AND:  trigger_ext_o = src_and;
         COMBINE_NAND: trigger_ext_o = ~src_and;
         default:      trigger_ext_o = 1'b0;      // off
      endcase
   end

   // module mux, purely combinational
   always_comb begin
      case (trig_module_i)
         MOD_EDGE:      trigger_o = trigger_ext_o;
         MOD_ADVIO:     trigger_o = trigger_advio_i;
         MOD_SAD:       trigger_o = trigger_sad_i;
         MOD_DECODEDIO: trigger_o = trigger_decodedio_i;
         MOD_TRACE:     trigger_o = trigger_trace_i;
         MOD_ADC:       trigger_o = trigger_adc_i;
         MOD_EDGE_DET:  trigger_o = trigger_edge_i;
         default:       trigger_o = 1'b0;         // none
      endcase
   end

   // one hot by construction, one enum value each
   assign decodeio_active_o     = (trig_module_i == MOD_DECODEDIO);
   assign sad_active_o          = (trig_module_i == MOD_SAD);
   assign edge_trigger_active_o = (trig_module_i == MOD_EDGE_DET);

endmodule

/* hdl/target_io_router.sv */
`timescale 1ns/100ps
`include "cw_io_settings.svh"

module target_io_router (
   input  logic                        clk_usb,
   input  logic                        reset,

   // config from register file
   input  logic [8*`CW_NUM_PINS-1:0]   pin_route_i,      // one byte per pin
   input  logic                        power_off_req_i,
   input  logic                        avrprog_en_i,
   input  logic [2:0]                  extra_gpio_oe_i,
   input  logic [2:0]                  extra_gpio_i,

   // target pins, split tri-state
   input  logic [`CW_NUM_PINS-1:0]     targetio_i,
   output logic [`CW_NUM_PINS-1:0]     targetio_o,
   output logic [`CW_NUM_PINS-1:0]     targetio_oe_o,

   input  logic                        uart_tx_i,
   output logic                        uart_rx_o,

   output logic                        targetpower_off_o,
   output logic [`CW_NUM_PINS-1:0]     io_sample_o,      // to ioread
   output logic                        enable_avrprog_o,
   output logic [2:0]                  extra_gpio_oe_o,  // pdic, pdid, nrst
   output logic [2:0]                  extra_gpio_o
);

   logic                     power_off_q;
   logic [`CW_NUM_PINS-1:0]  io_sample_q;

   // power register, one edge behind the request
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         power_off_q <= 1'b0;
      end else begin
         power_off_q <= power_off_req_i;
      end
   end

   // pin levels seen one cycle later
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         io_sample_q <= '0;
      end else begin
         io_sample_q <= targetio_i;
      end
   end

   // pin drivers, first matching rule wins
   always_comb begin
      for (int p = 0; p < `CW_NUM_PINS; p++) begin
         targetio_o[p]    = 1'b0;
         targetio_oe_o[p] = 1'b0;                 // default high-z
         if (power_off_q) begin
            targetio_oe_o[p] = 1'b0;              // target unpowered, never drive
         end else if (pin_route_i[p*8 + `ROUTE_TX]) begin
            targetio_o[p]    = uart_tx_i;
            targetio_oe_o[p] = 1'b1;
         end else if ((p == `CW_OC_PIN) && pin_route_i[p*8 + `ROUTE_LOW]) begin
            targetio_oe_o[p] = 1'b1;              // forced low
         end else if ((p == `CW_OC_PIN) && pin_route_i[p*8 + `ROUTE_OC]) begin
            targetio_oe_o[p] = ~uart_tx_i;        // pull low only, release on 1
         end else if (pin_route_i[p*8 + `ROUTE_GPIO]) begin
            targetio_o[p]    = pin_route_i[p*8 + `ROUTE_LEVEL];
            targetio_oe_o[p] = 1'b1;
         end
      end
   end

   // rx from lowest numbered rx pin, idle high if none
   always_comb begin
      uart_rx_o = 1'b1;
      for (int p = `CW_NUM_PINS - 1; p >= 0; p--) begin
         if (pin_route_i[p*8 + `ROUTE_RX]) uart_rx_o = targetio_i[p]; // lower pin overrides
      end
   end

   assign targetpower_off_o = power_off_q;
   assign io_sample_o       = io_sample_q;

   // straight register bits
   assign enable_avrprog_o = avrprog_en_i;
   assign extra_gpio_oe_o  = extra_gpio_oe_i;
   assign extra_gpio_o     = extra_gpio_i;

endmodule

/* hdl/cw_io_top.sv */
`timescale 1ns/100ps
`include "cw_io_settings.svh"

module cw_io_top
   import cw_io_pkg::*;
(
   input  logic                          clk_usb,
   input  logic                          reset,

   // register bus
   input  logic [`CW_ADDR_WIDTH-1:0]     reg_address_i,
   input  logic [`CW_BYTECNT_WIDTH-1:0]  reg_bytecnt_i,
   input  logic [`CW_DATA_WIDTH-1:0]     reg_data_i,
   input  logic                          reg_read_i,
   input  logic                          reg_write_i,
   output logic [`CW_DATA_WIDTH-1:0]     reg_data_o,

   // triggers
   input  logic                          trigger_aux_i,   // aux mcx
   input  logic                          trigger_nrst_i,
   input  logic [`CW_NUM_PINS-1:0]       trigger_io_i,
   input  logic                          trigger_advio_i,
   input  logic                          trigger_sad_i,
   input  logic                          trigger_decodedio_i,
   input  logic                          trigger_trace_i,
   input  logic                          trigger_adc_i,
   input  logic                          trigger_edge_i,
   output logic                          trigger_o,
   output logic                          trigger_ext_o,
   output logic                          decodeio_active_o,
   output logic                          sad_active_o,
   output logic                          edge_trigger_active_o,

   // target pins
   input  logic [`CW_NUM_PINS-1:0]       targetio_i,
   output logic [`CW_NUM_PINS-1:0]       targetio_o,
   output logic [`CW_NUM_PINS-1:0]       targetio_oe_o,
   input  logic                          uart_tx_i,
   output logic                          uart_rx_o,
   output logic                          targetpower_off_o,
   output logic                          enable_avrprog_o,
   output logic [2:0]                    extra_gpio_oe_o, // pdic, pdid, nrst
   output logic [2:0]                    extra_gpio_o
);

   logic [`CW_NUM_TRIG_SRC-1:0]  trig_src_en;
   trig_combine_e                trig_combine;
   trig_module_e                 trig_module;
   logic [8*`CW_NUM_PINS-1:0]    pin_route;
   logic                         power_off_req;
   logic                         avrprog_en;
   logic [2:0]                   gpio_oe;
   logic [2:0]                   gpio_out;
   logic [`CW_NUM_PINS-1:0]      io_sample;

   // registers and read mux
   cw_reg_file cw_reg_file_inst (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .reg_address_i   (reg_address_i),
      .reg_bytecnt_i   (reg_bytecnt_i),
      .reg_data_i      (reg_data_i),
      .reg_read_i      (reg_read_i),
      .reg_write_i     (reg_write_i),
      .reg_data_o      (reg_data_o),
      .io_sample_i     (io_sample),
      .trig_src_en_o   (trig_src_en),
      .trig_combine_o  (trig_combine),
      .trig_module_o   (trig_module),
      .pin_route_o     (pin_route),
      .power_off_req_o (power_off_req),
      .avrprog_en_o    (avrprog_en),
      .extra_gpio_oe_o (gpio_oe),
      .extra_gpio_o    (gpio_out)
   );

   // combiner and module mux
   trigger_select trigger_select_inst (
      .trig_src_en_i         (trig_src_en),
      .trig_combine_i        (trig_combine),
      .trig_module_i         (trig_module),
      .trigger_aux_i         (trigger_aux_i),
      .trigger_nrst_i        (trigger_nrst_i),
      .trigger_io_i          (trigger_io_i),
      .trigger_advio_i       (trigger_advio_i),
      .trigger_sad_i         (trigger_sad_i),
      .trigger_decodedio_i   (trigger_decodedio_i),
      .trigger_trace_i       (trigger_trace_i),
      .trigger_adc_i         (trigger_adc_i),
      .trigger_edge_i        (trigger_edge_i),
      .trigger_o             (trigger_o),
      .trigger_ext_o         (trigger_ext_o),
      .decodeio_active_o     (decodeio_active_o),
      .sad_active_o          (sad_active_o),
      .edge_trigger_active_o (edge_trigger_active_o)
   );

   // pins, rx, power
   target_io_router target_io_router_inst (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .pin_route_i       (pin_route),
      .power_off_req_i   (power_off_req),
      .avrprog_en_i      (avrprog_en),
      .extra_gpio_oe_i   (gpio_oe),
      .extra_gpio_i      (gpio_out),
      .targetio_i        (targetio_i),
      .targetio_o        (targetio_o),
      .targetio_oe_o     (targetio_oe_o),
      .uart_tx_i         (uart_tx_i),
      .uart_rx_o         (uart_rx_o),
      .targetpower_off_o (targetpower_off_o),
      .io_sample_o       (io_sample),
      .enable_avrprog_o  (enable_avrprog_o),
      .extra_gpio_oe_o   (extra_gpio_oe_o),
      .extra_gpio_o      (extra_gpio_o)
   );

endmodule

/* verif/cw_io_assertions.sv */
`timescale 1ns/100ps
`include "cw_io_settings.svh"

module cw_io_assertions (
   input logic                          clk_usb,
   input logic                          reset,
   input logic [`CW_ADDR_WIDTH-1:0]     reg_address_i,
   input logic [`CW_BYTECNT_WIDTH-1:0]  reg_bytecnt_i,
   input logic [`CW_DATA_WIDTH-1:0]     reg_data_i,
   input logic                          reg_read_i,
   input logic                          reg_write_i,
   input logic [`CW_DATA_WIDTH-1:0]     reg_data_o,
   input logic [`CW_NUM_PINS-1:0]       targetio_oe_o,
   input logic                          targetpower_off_o,
   input logic                          decodeio_active_o,
   input logic                          sad_active_o,
   input logic                          edge_trigger_active_o
);

   int   fail_count = 0;  // read by the testbench at the end
   logic wr5_d1, wr5_d2; // byte 5 write, delayed
   logic bit_d1, bit_d2; // power bit of that write

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         wr5_d1 <= 1'b0;
         wr5_d2 <= 1'b0;
      end else begin
         wr5_d1 <= reg_write_i && (reg_address_i == `CW_IOROUTE_ADDR)
                   && (reg_bytecnt_i == `CW_BYTECNT_WIDTH'(`CW_EXTRA_BYTE));
         wr5_d2 <= wr5_d1;
      end
      bit_d1 <= reg_data_i[`CW_POWER_OFF_BIT];
      bit_d2 <= bit_d1;
   end

   oe_off_when_unpowered: assert property (@(posedge clk_usb) disable iff (reset)
      targetpower_off_o |-> (targetio_oe_o == '0))
      else begin $error("pin driven while target power off"); fail_count++; end

   read_idle_zero: assert property (@(posedge clk_usb) disable iff (reset)
      !reg_read_i |-> (reg_data_o == '0))
      else begin $error("read data nonzero without read strobe"); fail_count++; end

   active_onehot: assert property (@(posedge clk_usb) disable iff (reset)
      $onehot0({decodeio_active_o, sad_active_o, edge_trigger_active_o}))
      else begin $error("more than one active flag"); fail_count++; end

   power_two_edges: assert property (@(posedge clk_usb) disable iff (reset)
      wr5_d2 |-> (targetpower_off_o == bit_d2))
      else begin $error("power off not updated two edges after write"); fail_count++; end

endmodule

bind cw_io_top cw_io_assertions cw_io_assertions_inst (
   .clk_usb(clk_usb), .reset(reset), .reg_address_i(reg_address_i),
   .reg_bytecnt_i(reg_bytecnt_i), .reg_data_i(reg_data_i), .reg_read_i(reg_read_i),
   .reg_write_i(reg_write_i), .reg_data_o(reg_data_o), .targetio_oe_o(targetio_oe_o),
   .targetpower_off_o(targetpower_off_o), .decodeio_active_o(decodeio_active_o),
   .sad_active_o(sad_active_o), .edge_trigger_active_o(edge_trigger_active_o)
);

/* verif/cw_io_tb.sv */
`timescale 1ns/100ps
`include "cw_io_settings.svh"

module cw_io_tb import cw_io_pkg::*; ;

   localparam int MAX_CYCLES = 5000; // run needs well under 1000 cycles
   logic clk_usb = 1'b0, reset = 1'b1;
   logic [7:0] reg_address_i = '0, reg_data_i = '0, reg_data_o;
   logic [6:0] reg_bytecnt_i = '0;
   logic reg_read_i = 1'b0, reg_write_i = 1'b0;
   logic trigger_aux_i = 0, trigger_nrst_i = 0, trigger_advio_i = 0, trigger_sad_i = 0;
   logic trigger_decodedio_i = 0, trigger_trace_i = 0, trigger_adc_i = 0, trigger_edge_i = 0;
   logic [3:0] trigger_io_i = '0, targetio_i = '0, targetio_o, targetio_oe_o;
   logic trigger_o, trigger_ext_o, decodeio_active_o, sad_active_o, edge_trigger_active_o;
   logic uart_tx_i = 1'b1, uart_rx_o, targetpower_off_o, enable_avrprog_o;
   logic [2:0] extra_gpio_oe_o, extra_gpio_o;
   logic [7:0] trigsrc_m, trigmod_m, route_m [8]; // register model
   int errors = 0, checks = 0, cycle_count = 0;

   cw_io_top cw_io_top_inst (.*);

   always #10 clk_usb = ~clk_usb;

   always @(posedge clk_usb) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
      checks++;
      assert (got === exp) else begin
         $display("FAIL %s expected 0x%0h got 0x%0h", name, exp, got);
         errors++;
      end
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [6:0] cnt, input logic [7:0] d);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_bytecnt_i <= cnt;
      reg_data_i    <= d;
      reg_write_i   <= 1'b1;
      @(posedge clk_usb);
      reg_write_i <= 1'b0;
      if (addr == `CW_TRIGSRC_ADDR) trigsrc_m = d;
      if (addr == `CW_TRIGMOD_ADDR) trigmod_m = d;
      if (addr == `CW_IOROUTE_ADDR && cnt < 8) route_m[cnt] = d;
   endtask

   task automatic read_expect(input string name, input logic [7:0] addr, input logic [6:0] cnt,
                              input logic [7:0] exp);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_bytecnt_i <= cnt;
      reg_read_i    <= 1'b1;
      @(negedge clk_usb);
      check_val($sformatf("reg_data_o (%s)", name), exp, reg_data_o);
      @(posedge clk_usb);
      reg_read_i <= 1'b0;
   endtask

   // pins change on the read edge, ioread shows them one edge later
   task automatic expect_ioread_lag();
      logic [7:0] prev_lvl;
      @(posedge clk_usb);
      prev_lvl = {4'h0, targetio_i};   // still the old levels here
      reg_address_i <= `CW_IOREAD_ADDR;
      reg_bytecnt_i <= '0;
      reg_read_i    <= 1'b1;
      targetio_i    <= 4'($urandom);
      @(negedge clk_usb);
      check_val("reg_data_o (ioread before edge)", prev_lvl, reg_data_o);
      @(negedge clk_usb);
      check_val("reg_data_o (ioread after edge)", {4'h0, targetio_i}, reg_data_o);
      @(posedge clk_usb);
      reg_read_i <= 1'b0;
   endtask

   task automatic drive_random_triggers();
      @(posedge clk_usb);
      {trigger_aux_i, trigger_nrst_i, trigger_advio_i, trigger_sad_i} <= 4'($urandom);
      {trigger_decodedio_i, trigger_trace_i, trigger_adc_i, trigger_edge_i} <= 4'($urandom);
      trigger_io_i <= 4'($urandom);
      @(negedge clk_usb);
   endtask

   function automatic logic combine_model(input logic [7:0] cfg, input logic [5:0] src);
      logic any_hit = 1'b0, all_hit = 1'b1;
      for (int i = 0; i < 6; i++) if (cfg[i]) begin
         any_hit |= src[i];
         all_hit &= src[i];
      end
      case (cfg[7:6])
         2'd0: return any_hit;
         2'd1: return all_hit;
         2'd2: return !all_hit;
         default: return 1'b0;
      endcase
   endfunction

   // full pin, rx and extra output check against the model
   task automatic check_pins(input logic pwr);
      logic oe, val, rx, found = 1'b0;
      for (int p = 0; p < 4; p++) begin
         val = 1'b0;
         if (pwr) begin
            oe = 1'b0;
         end else if (route_m[p][`ROUTE_TX]) begin
            oe  = 1'b1;
            val = uart_tx_i;
         end else if (p == 2 && route_m[p][`ROUTE_LOW]) begin
            oe = 1'b1;
         end else if (p == 2 && route_m[p][`ROUTE_OC]) begin
            oe = !uart_tx_i;
         end else if (route_m[p][`ROUTE_GPIO]) begin
            oe  = 1'b1;
            val = route_m[p][`ROUTE_LEVEL];
         end else begin
            oe = 1'b0;
         end
         check_val($sformatf("targetio_oe_o[%0d]", p), oe, targetio_oe_o[p]);
         if (oe) check_val($sformatf("targetio_o[%0d]", p), val, targetio_o[p]);
      end
      rx = 1'b1;
      for (int p = 0; p < 4; p++) if (!found && route_m[p][`ROUTE_RX]) begin
         rx = targetio_i[p];
         found = 1'b1;
      end
      check_val("uart_rx_o", rx, uart_rx_o);
      check_val("targetpower_off_o", pwr, targetpower_off_o);
      check_val("enable_avrprog_o", route_m[5][0], enable_avrprog_o);
      check_val("extra_gpio_oe_o", {route_m[6][4], route_m[6][2], route_m[6][0]}, extra_gpio_oe_o);
      check_val("extra_gpio_o", {route_m[6][5], route_m[6][3], route_m[6][1]}, extra_gpio_o);
   endtask

   task automatic end_test(input int num, input string name, input int err_before);
      $display("test %0d %s: %0d errors", num, name, errors - err_before);
   endtask

   initial begin
      int e;
      logic [7:0] d;
      void'($urandom(32'h3580));
      trigsrc_m = `CW_TRIGSRC_RESET;
      trigmod_m = `CW_TRIGMOD_RESET;
      for (int b = 0; b < 8; b++) route_m[b] = 8'(`CW_IOROUTE_RESET >> (8 * b));
      repeat (5) @(posedge clk_usb);
      reset <= 1'b0;

      e = errors; // 1 reset state
      @(posedge clk_usb) targetio_i <= 4'h9;
      read_expect("trigsrc", `CW_TRIGSRC_ADDR, 0, 8'h20);
      read_expect("trigmod", `CW_TRIGMOD_ADDR, 0, 8'h00);
      for (int b = 0; b < 8; b++) read_expect("ioroute", `CW_IOROUTE_ADDR, 7'(b), route_m[b]);
      read_expect("ioread", `CW_IOREAD_ADDR, 0, 8'h09);
      drive_random_triggers();
      check_val("trigger_o", trigger_io_i[3], trigger_o);
      check_val("{decodeio,sad,edge_trigger}_active_o", 3'b000,
                {decodeio_active_o, sad_active_o, edge_trigger_active_o});
      check_pins(1'b0);
      end_test(1, "reset state", e);

      e = errors; // 2 register readback
      reg_write(`CW_TRIGSRC_ADDR, 0, 8'($urandom));
      reg_write(`CW_TRIGMOD_ADDR, 0, 8'($urandom));
      for (int b = 0; b < 8; b++) reg_write(`CW_IOROUTE_ADDR, 7'(b), 8'($urandom));
      read_expect("trigsrc", `CW_TRIGSRC_ADDR, 0, trigsrc_m);
      read_expect("trigmod", `CW_TRIGMOD_ADDR, 0, trigmod_m);
      reg_write(`CW_IOROUTE_ADDR, 7'd8, 8'hff); // must not alias byte 0
      for (int b = 0; b < 8; b++) read_expect("ioroute", `CW_IOROUTE_ADDR, 7'(b), route_m[b]);
      read_expect("unknown addr", 8'h10, 0, 8'h00);
      read_expect("ioroute high bytecnt", `CW_IOROUTE_ADDR, 7'd9, 8'h00);
      reg_write(`CW_IOROUTE_ADDR, 5, 8'h00);
      end_test(2, "register readback", e);

      e = errors; // 3 combine modes
      reg_write(`CW_TRIGMOD_ADDR, 0, {5'd0, MOD_EDGE});
      for (int m = 0; m < 4; m++) begin
         repeat (8) begin
            reg_write(`CW_TRIGSRC_ADDR, 0, {2'(m), 6'($urandom)});
            repeat (4) begin
               drive_random_triggers();
               d[0] = combine_model(trigsrc_m, {trigger_io_i, trigger_nrst_i, trigger_aux_i});
               check_val("trigger_ext_o", d[0], trigger_ext_o);
               check_val("trigger_o", d[0], trigger_o);
            end
         end
      end
      end_test(3, "combine modes", e);

      e = errors; // 4 module select
      for (int m = 0; m < 8; m++) begin
         reg_write(`CW_TRIGMOD_ADDR, 0, 8'(m));
         repeat (8) begin
            drive_random_triggers();
            case (m)
               0: d[0] = combine_model(trigsrc_m, {trigger_io_i, trigger_nrst_i, trigger_aux_i});
               1: d[0] = trigger_advio_i;
               2: d[0] = trigger_sad_i;
               3: d[0] = trigger_decodedio_i;
               4: d[0] = trigger_trace_i;
               5: d[0] = trigger_adc_i;
               6: d[0] = trigger_edge_i;
               default: d[0] = 1'b0;
            endcase
            check_val("trigger_o", d[0], trigger_o);
            check_val("decodeio_active_o", m == 3, decodeio_active_o);
            check_val("sad_active_o", m == 2, sad_active_o);
            check_val("edge_trigger_active_o", m == 6, edge_trigger_active_o);
         end
      end
      end_test(4, "module select", e);

      e = errors; // 5 pin routing
      repeat (24) begin
         for (int p = 0; p < 4; p++) begin
            case ($urandom_range(0, 6))
               0: d = 8'h01;              // tx
               1: d = 8'h80;              // static low
               2: d = 8'hc0;              // static high
               3: d = 8'h00;              // high-z
               4: d = 8'h10;              // forced low, pin 3 only
               5: d = 8'h20;              // open collector, pin 3 only
               default: d = 8'($urandom);
            endcase
            reg_write(`CW_IOROUTE_ADDR, 7'(p), d | ($urandom_range(0, 2) == 0 ? 8'h02 : 8'h00));
         end
         reg_write(`CW_IOROUTE_ADDR, 5, 8'($urandom_range(0, 1)));
         reg_write(`CW_IOROUTE_ADDR, 6, 8'($urandom));
         for (int t = 0; t < 2; t++) begin
            @(posedge clk_usb);
            uart_tx_i <= t[0];
            targetio_i <= 4'($urandom);
            @(negedge clk_usb);
            check_pins(1'b0);
         end
         expect_ioread_lag();
      end
      end_test(5, "pin routing", e);

      e = errors; // 6 target power off
      for (int p = 0; p < 4; p++) reg_write(`CW_IOROUTE_ADDR, 7'(p), 8'h81);
      reg_write(`CW_IOROUTE_ADDR, 5, 8'h02);
      @(negedge clk_usb) check_val("targetpower_off_o", 1'b0, targetpower_off_o);
      @(negedge clk_usb) check_pins(1'b1);
      repeat (6) begin
         reg_write(`CW_IOROUTE_ADDR, 7'($urandom_range(0, 3)), 8'($urandom));
         @(negedge clk_usb) check_pins(1'b1);
      end
      reg_write(`CW_IOROUTE_ADDR, 5, 8'h00);
      @(negedge clk_usb) check_val("targetpower_off_o", 1'b1, targetpower_off_o);
      @(negedge clk_usb) check_pins(1'b0);
      end_test(6, "target power", e);

      errors += cw_io_top_inst.cw_io_assertions_inst.fail_count;
      $display("tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+hdl
hdl/cw_io_pkg.sv
hdl/cw_reg_file.sv
hdl/trigger_select.sv
hdl/target_io_router.sv
hdl/cw_io_top.sv
verif/cw_io_assertions.sv
verif/cw_io_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= cw_io_tb
FILELIST   ?= verilog.f
PASS_MSG   := All tests passed

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST) $(wildcard hdl/*) $(wildcard verif/*)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
